/* include/imem_consts.svh */
`ifndef IMEM_CONSTS_SVH
`define IMEM_CONSTS_SVH

// program memory size in 32-bit words
`define IMEM_DEPTH 128
`define IMEM_AW 7

// register map, AXI byte addresses
`define CTRL_ADDR 32'h0000_0400
`define STAT_ADDR 32'h0000_0404

// words preloaded at power-up
`define BOOT_LEN 8

// AXI4-Lite response codes
`define AXI_RESP_OKAY 2'b00
`define AXI_RESP_SLVERR 2'b10

`endif

/* hw/isa_pkg.sv */
`include "imem_consts.svh"

package isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [`IMEM_AW-1:0] imem_addr_t;	// word address, not byte
	typedef logic [25:0] jump_target_t;

	// primary opcode in bits 31:26
	typedef enum logic [5:0] {
		OP_ADD = 6'b000000,	// register group, funct field picks the op
		OP_ADDI = 6'b000001,
		OP_SUBI = 6'b000010,
		OP_MOV = 6'b001110,
		OP_LW = 6'b001111,
		OP_LI = 6'b010000,
		OP_LA = 6'b010001,
		OP_SW = 6'b010010,
		OP_IN = 6'b010011,
		OP_OUT = 6'b010100,
		OP_JF = 6'b010101,	// conditional, needs a register
		OP_J = 6'b010110,
		OP_JAL = 6'b010111,
		OP_HALT = 6'b011000
	} opcode_e;

	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_RUN,
		FETCH_HALTED,
		FETCH_FAULT
	} fetch_state_e;

endpackage

/* hw/bus_pkg.sv */
package bus_pkg;
	import isa_pkg::*;

	typedef logic [31:0] axil_addr_t;
	typedef logic [1:0] axil_resp_t;

	// one access on the shared memory port
	typedef struct packed {
		logic valid;
		logic we;	// 0 for a read
		imem_addr_t addr;
		word_t data;
	} mem_req_t;

	typedef struct packed {
		axil_addr_t addr;
	} axil_aw_t;

	typedef struct packed {
		word_t data;
		logic [3:0] strb;	// full words only
	} axil_w_t;

	typedef struct packed {
		axil_resp_t resp;
	} axil_b_t;

	typedef struct packed {
		axil_addr_t addr;
	} axil_ar_t;

	typedef struct packed {
		word_t data;
		axil_resp_t resp;
	} axil_r_t;

	// fetched instruction with its word address
	typedef struct packed {
		imem_addr_t pc;
		word_t word;
	} fetch_out_t;

endpackage

/* hw/instr_mem.sv */
`timescale 1ns/10ps
`include "imem_consts.svh"

module instr_mem import isa_pkg::*, bus_pkg::*; (
	input logic clk,
	input mem_req_t req,
	output word_t rdata
);

	word_t mem [`IMEM_DEPTH];

	// boot program: jump over setup, call a routine, halt
	// fetch order is 0, 3, 4, 6, 7
	function automatic word_t boot_word(input int unsigned idx);
		case (idx)
			0: return {OP_J, 26'd3};
			1: return {OP_ADDI, 5'd30, 5'd30, 16'h0008};	// skipped
			2: return {OP_SW, 5'd30, 5'd6, 16'hfffb};	// skipped
			3: return {OP_LI, 5'd0, 5'd20, 16'h0009};
			4: return {OP_JAL, 26'd6};
			5: return {OP_MOV, 5'd1, 5'd11, 16'h0000};	// return point, not reached
			6: return {OP_OUT, 5'd0, 5'd6, 16'h0002};
			7: return {OP_HALT, 26'd0};
			default: return '0;
		endcase
	endfunction

	initial begin
		for (int i = 0; i < `IMEM_DEPTH; i++) begin
			mem[i] = (i < `BOOT_LEN) ? boot_word(i) : '0;
		end
	end

	assign rdata = mem[req.addr];	// combinational read

	always @(posedge clk) begin
		if (req.valid && req.we) begin
			mem[req.addr] <= req.data;
		end
	end

endmodule

/* hw/mem_arbiter.sv */
`timescale 1ns/10ps

module mem_arbiter import bus_pkg::*; (
	input mem_req_t loader_req,
	input mem_req_t fetch_req,
	output logic loader_gnt,
	output logic fetch_gnt,
	output mem_req_t mem_req
);

	// loader has fixed priority, fetcher only gets idle cycles
	assign loader_gnt = loader_req.valid;
	assign fetch_gnt = fetch_req.valid && !loader_req.valid;

	always_comb begin
		if (loader_gnt) begin
			mem_req = loader_req;
		end else begin
			mem_req = fetch_req;	// valid low unless fetch is granted
		end
	end

endmodule

/* hw/axil_loader.sv */
`timescale 1ns/10ps
`include "imem_consts.svh"

module axil_loader import isa_pkg::*, bus_pkg::*; (
	input logic clk,
	input logic rst_n,
	input axil_aw_t aw,
	input logic aw_valid,
	output logic aw_ready,
	input axil_w_t w,
	input logic w_valid,
	output logic w_ready,
	output axil_b_t b,
	output logic b_valid,
	input logic b_ready,
	input axil_ar_t ar,
	input logic ar_valid,
	output logic ar_ready,
	output axil_r_t r,
	output logic r_valid,
	input logic r_ready,
	output mem_req_t mem_req,
	input logic mem_gnt,
	input word_t mem_rdata,
	output logic start,
	input logic running,
	input logic halted,
	input logic fault
);

	typedef enum logic [2:0] {
		LD_IDLE,
		LD_WR_EXEC,	// write decoded and applied
		LD_RD_EXEC,
		LD_B_RESP,
		LD_R_RESP
	} ld_state_e;

	ld_state_e state;
	axil_addr_t req_addr;	// latched byte address
	word_t wdata;
	logic rd_accept;
	logic wr_accept;
	logic is_mem;
	logic is_ctrl;
	logic is_stat;
	logic mapped;
	word_t status_word;

	assign rd_accept = (state == LD_IDLE) && ar_valid;
	assign wr_accept = (state == LD_IDLE) && aw_valid && w_valid && !ar_valid;	// read wins a tie
	assign ar_ready = rd_accept;
	assign aw_ready = wr_accept;
	assign w_ready = wr_accept;

	assign is_mem = req_addr < (`IMEM_DEPTH * 4);
	assign is_ctrl = req_addr == `CTRL_ADDR;
	assign is_stat = req_addr == `STAT_ADDR;
	assign mapped = is_mem || is_ctrl || is_stat;
	assign status_word = {29'd0, fault, halted, running};

	assign mem_req.valid = ((state == LD_WR_EXEC) || (state == LD_RD_EXEC)) && is_mem;
	assign mem_req.we = state == LD_WR_EXEC;
	assign mem_req.addr = req_addr[`IMEM_AW+1:2];	// byte to word address
	assign mem_req.data = wdata;

	assign start = (state == LD_WR_EXEC) && is_ctrl && wdata[0];	// run bit, one cycle

	assign b_valid = state == LD_B_RESP;
	assign r_valid = state == LD_R_RESP;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= LD_IDLE;
		end else begin
			case (state)
				LD_IDLE: begin
					if (rd_accept) state <= LD_RD_EXEC;
					else if (wr_accept) state <= LD_WR_EXEC;
				end
				LD_WR_EXEC: if (!is_mem || mem_gnt) state <= LD_B_RESP;
				LD_RD_EXEC: if (!is_mem || mem_gnt) state <= LD_R_RESP;
				LD_B_RESP: if (b_ready) state <= LD_IDLE;
				LD_R_RESP: if (r_ready) state <= LD_IDLE;
				default: state <= LD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rd_accept) begin
			req_addr <= ar.addr;
		end else if (wr_accept) begin
			req_addr <= aw.addr;
			wdata <= w.data;
		end
		if (state == LD_WR_EXEC) begin
			b.resp <= mapped ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
		end
		if (state == LD_RD_EXEC) begin
			if (is_mem) r.data <= mem_rdata;	// final capture is the granted cycle
			else if (is_stat) r.data <= status_word;
			else r.data <= '0;	// ctrl reads as zero, run bit self-clears
			r.resp <= mapped ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
		end
	end

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/10ps
`include "imem_consts.svh"

module fetch_unit import isa_pkg::*, bus_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic start,
	output mem_req_t mem_req,
	input logic mem_gnt,
	input word_t mem_rdata,
	output fetch_out_t inst,
	output logic inst_valid,
	input logic inst_ready,
	output logic running,
	output logic halted,
	output logic fault
);

	fetch_state_e state;
	imem_addr_t pc;	// next word to fetch
	logic stop;	// last word is fetched
	logic last_is_halt;
	logic out_valid;
	fetch_out_t out_q;
	logic rd_fire;
	logic out_fire;
	opcode_e op;
	jump_target_t target;
	imem_addr_t next_pc;
	logic next_stop;
	logic next_halt;

	assign out_fire = out_valid && inst_ready;

	// fetch only when the output slot is free or drains this cycle
	assign mem_req.valid = (state == FETCH_RUN) && !stop && (!out_valid || inst_ready);
	assign mem_req.we = 1'b0;
	assign mem_req.addr = pc;
	assign mem_req.data = '0;
	assign rd_fire = mem_req.valid && mem_gnt;

	assign op = opcode_e'(mem_rdata[31:26]);
	assign target = mem_rdata[25:0];

	always_comb begin
		next_pc = pc + 1'b1;
		next_stop = 1'b0;
		next_halt = 1'b0;
		case (op)
			OP_J, OP_JAL: begin
				next_pc = target[`IMEM_AW-1:0];
				next_stop = target >= `IMEM_DEPTH;	// leaves memory, fault
			end
			OP_HALT: begin
				next_stop = 1'b1;
				next_halt = 1'b1;
			end
			default: next_stop = pc == imem_addr_t'(`IMEM_DEPTH - 1);	// runs off the end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= FETCH_IDLE;
			pc <= '0;
			stop <= 1'b0;
			last_is_halt <= 1'b0;
			out_valid <= 1'b0;
		end else if (start && state != FETCH_RUN) begin
			state <= FETCH_RUN;	// also restarts from halted or fault
			pc <= '0;
			stop <= 1'b0;
			out_valid <= 1'b0;
		end else if (state == FETCH_RUN) begin
			if (rd_fire) begin
				pc <= next_pc;
				stop <= next_stop;
				last_is_halt <= next_halt;
				out_valid <= 1'b1;
			end else if (out_fire) begin
				out_valid <= 1'b0;
			end
			// final word handed off
			if (out_fire && stop) state <= last_is_halt ? FETCH_HALTED : FETCH_FAULT;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_fire) out_q <= '{pc: pc, word: mem_rdata};
	end

	assign inst = out_q;
	assign inst_valid = out_valid;
	assign running = state == FETCH_RUN;
	assign halted = state == FETCH_HALTED;
	assign fault = state == FETCH_FAULT;

endmodule

/* hw/imem_subsys_top.sv */
`timescale 1ns/10ps

module imem_subsys_top import isa_pkg::*, bus_pkg::*; (
	input logic clk,
	input logic rst_n,
	input axil_aw_t aw,
	input logic aw_valid,
	output logic aw_ready,
	input axil_w_t w,
	input logic w_valid,
	output logic w_ready,
	output axil_b_t b,
	output logic b_valid,
	input logic b_ready,
	input axil_ar_t ar,
	input logic ar_valid,
	output logic ar_ready,
	output axil_r_t r,
	output logic r_valid,
	input logic r_ready,
	output fetch_out_t inst,
	output logic inst_valid,
	input logic inst_ready,
	output logic running,
	output logic halted,
	output logic fault
);

	mem_req_t loader_req;
	mem_req_t fetch_req;
	mem_req_t mem_req;	// arbitrated port into the memory
	logic loader_gnt;
	logic fetch_gnt;
	word_t mem_rdata;
	logic start;

	instr_mem u_instr_mem (
		.clk(clk),
		.req(mem_req),
		.rdata(mem_rdata)
	);

	mem_arbiter u_mem_arbiter (
		.loader_req(loader_req),
		.fetch_req(fetch_req),
		.loader_gnt(loader_gnt),
		.fetch_gnt(fetch_gnt),
		.mem_req(mem_req)
	);

	axil_loader u_axil_loader (
		.clk(clk),
		.rst_n(rst_n),
		.aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
		.w(w), .w_valid(w_valid), .w_ready(w_ready),
		.b(b), .b_valid(b_valid), .b_ready(b_ready),
		.ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.r(r), .r_valid(r_valid), .r_ready(r_ready),
		.mem_req(loader_req),
		.mem_gnt(loader_gnt),
		.mem_rdata(mem_rdata),
		.start(start),
		.running(running),
		.halted(halted),
		.fault(fault)
	);

	fetch_unit u_fetch_unit (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.mem_req(fetch_req),
		.mem_gnt(fetch_gnt),
		.mem_rdata(mem_rdata),
		.inst(inst),
		.inst_valid(inst_valid),
		.inst_ready(inst_ready),
		.running(running),
		.halted(halted),
		.fault(fault)
	);

endmodule

/* verification/imem_subsys_chk.sv */
`timescale 1ns/10ps

module imem_subsys_chk import bus_pkg::*; (
	input logic clk,
	input logic rst_n,
	input axil_aw_t aw,
	input logic aw_valid,
	input logic aw_ready,
	input axil_w_t w,
	input logic w_valid,
	input logic w_ready,
	input axil_ar_t ar,
	input logic ar_valid,
	input logic ar_ready,
	input axil_b_t b,
	input logic b_valid,
	input logic b_ready,
	input axil_r_t r,
	input logic r_valid,
	input logic r_ready,
	input fetch_out_t inst,
	input logic inst_valid,
	input logic inst_ready,
	input mem_req_t loader_req,
	input logic loader_gnt,
	input logic fetch_gnt
);

	int n_fail = 0;	// read by the testbench

	// held payload until accepted
	a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw))
		else begin $error("aw dropped or changed before aw_ready"); n_fail++; end
	a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
		w_valid && !w_ready |=> w_valid && $stable(w))
		else begin $error("w dropped or changed before w_ready"); n_fail++; end
	a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
		else begin $error("ar dropped or changed before ar_ready"); n_fail++; end
	a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
		b_valid && !b_ready |=> b_valid && $stable(b))
		else begin $error("b dropped or changed before b_ready"); n_fail++; end
	a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		r_valid && !r_ready |=> r_valid && $stable(r))
		else begin $error("r dropped or changed before r_ready"); n_fail++; end
	a_inst_hold: assert property (@(posedge clk) disable iff (!rst_n)
		inst_valid && !inst_ready |=> inst_valid && $stable(inst))
		else begin $error("inst dropped or changed before inst_ready"); n_fail++; end

	// arbitration
	a_one_gnt: assert property (@(posedge clk) disable iff (!rst_n)
		!(loader_gnt && fetch_gnt))
		else begin $error("both memory grants high"); n_fail++; end
	a_loader_first: assert property (@(posedge clk) disable iff (!rst_n)
		loader_req.valid |-> !fetch_gnt)
		else begin $error("fetch granted while loader requests"); n_fail++; end

endmodule

bind imem_subsys_top imem_subsys_chk u_imem_subsys_chk (
	.clk(clk), .rst_n(rst_n),
	.aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
	.w(w), .w_valid(w_valid), .w_ready(w_ready),
	.ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
	.b(b), .b_valid(b_valid), .b_ready(b_ready),
	.r(r), .r_valid(r_valid), .r_ready(r_ready),
	.inst(inst), .inst_valid(inst_valid), .inst_ready(inst_ready),
	.loader_req(loader_req), .loader_gnt(loader_gnt), .fetch_gnt(fetch_gnt)
);

/* verification/imem_subsys_tb.sv */
`timescale 1ns/10ps
`include "imem_consts.svh"

module imem_subsys_tb import isa_pkg::*, bus_pkg::*; ();

	typedef enum logic [1:0] {K_WR, K_RD, K_RUN, K_DONE} step_kind_e;

	typedef struct packed {
		step_kind_e kind;
		axil_addr_t addr;
		word_t data;
		word_t exp;	// read data or status word
		axil_resp_t resp;
	} step_t;

	logic clk = 1'b0;
	logic rst_n;
	axil_aw_t aw;
	logic aw_valid;
	logic aw_ready;
	axil_w_t w;
	logic w_valid;
	logic w_ready;
	axil_b_t b;
	logic b_valid;
	logic b_ready;
	axil_ar_t ar;
	logic ar_valid;
	logic ar_ready;
	axil_r_t r;
	logic r_valid;
	logic r_ready;
	fetch_out_t inst;
	logic inst_valid;
	logic inst_ready;
	logic running;
	logic halted;
	logic fault;

	word_t model [`IMEM_DEPTH];	// expected memory contents
	fetch_out_t exp_q [$];
	step_t steps [$];
	logic [31:0] lfsr = 32'h88ddd587;
	int cycles = 0;
	int cycle_limit = 0;

	imem_subsys_top u_imem_subsys_top (.*);

	initial begin
		forever #50 clk = ~clk;
	end

	task automatic report_fail();
		$display("Verification failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h exp %h", name, got, exp);
			report_fail();
		end
	endtask

	task automatic check_resp(input string name, input axil_resp_t got, input axil_resp_t exp);
		if (got !== exp) begin
			$display("ERR %s got %h exp %h", name, got, exp);
			report_fail();
		end
	endtask

	task automatic check_fetch(input fetch_out_t got, input fetch_out_t exp);
		if (got !== exp) begin
			$display("ERR inst got %h exp %h", got, exp);
			report_fail();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %s got %h exp %h", name, got, exp);
			report_fail();
		end
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// taps 32 22 2 1
	endfunction

	// next-pc rule applied to the model, fills the expected stream
	task automatic walk_program();
		imem_addr_t pc;
		word_t wd;
		logic done;
		pc = '0;
		done = 1'b0;
		while (!done && exp_q.size() < 4 * `IMEM_DEPTH) begin
			wd = model[pc];
			exp_q.push_back('{pc: pc, word: wd});
			if (wd[31:26] == OP_J || wd[31:26] == OP_JAL) begin
				if (wd[25:0] >= `IMEM_DEPTH) done = 1'b1;	// fault
				else pc = wd[`IMEM_AW-1:0];
			end else if (wd[31:26] == OP_HALT) begin
				done = 1'b1;
			end else if (pc == `IMEM_DEPTH - 1) begin
				done = 1'b1;
			end else begin
				pc = pc + 1'b1;
			end
		end
	endtask

	task automatic axil_write(input axil_addr_t addr, input word_t data, output axil_resp_t resp);
		@(negedge clk);
		aw.addr = addr;
		w.data = data;
		w.strb = 4'hf;
		aw_valid = 1'b1;
		w_valid = 1'b1;
		do @(posedge clk); while (!aw_ready);
		check_flag("w_ready", w_ready, 1'b1);
		@(negedge clk);
		aw_valid = 1'b0;
		w_valid = 1'b0;
		repeat (2) @(negedge clk);	// response waits under back-pressure
		b_ready = 1'b1;
		do @(posedge clk); while (!b_valid);
		resp = b.resp;
		@(negedge clk);
		b_ready = 1'b0;
	endtask

	task automatic axil_read(input axil_addr_t addr, output word_t data, output axil_resp_t resp);
		@(negedge clk);
		ar.addr = addr;
		ar_valid = 1'b1;
		do @(posedge clk); while (!ar_ready);
		@(negedge clk);
		ar_valid = 1'b0;
		repeat (2) @(negedge clk);	// response waits under back-pressure
		r_ready = 1'b1;
		do @(posedge clk); while (!r_valid);
		data = r.data;
		resp = r.resp;
		@(negedge clk);
		r_ready = 1'b0;
	endtask

	task automatic add_step(input step_kind_e kind, input axil_addr_t addr, input word_t data,
			input word_t exp, input axil_resp_t resp);
		steps.push_back('{kind: kind, addr: addr, data: data, exp: exp, resp: resp});
	endtask

	// random back-pressure on the stream
	always @(negedge clk) begin
		lfsr = lfsr_next(lfsr);
		inst_ready = lfsr[0];
	end

	always @(posedge clk) begin
		if (rst_n && inst_valid && inst_ready) begin
			if (exp_q.size() == 0) begin
				$display("instruction at pc %h delivered when none was expected", inst.pc);
				report_fail();
			end else begin
				check_flag("running", running, 1'b1);
				check_fetch(inst, exp_q.pop_front());
			end
		end
	end

	always @(negedge clk) begin
		if (u_imem_subsys_top.u_imem_subsys_chk.n_fail != 0) begin
			$display("a protocol assertion in the checker failed");
			report_fail();
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit) begin
			$display("timeout, the run did not finish within %0d cycles", cycle_limit);
			report_fail();
		end
	end

	initial begin
		step_t st;
		word_t rd;
		axil_resp_t resp;
		rst_n = 1'b0;
		aw = '0;
		w = '0;
		ar = '0;
		aw_valid = 1'b0;
		w_valid = 1'b0;
		ar_valid = 1'b0;
		b_ready = 1'b0;
		r_ready = 1'b0;
		inst_ready = 1'b0;
		for (int i = 0; i < `IMEM_DEPTH; i++) model[i] = '0;
		model[0] = {OP_J, 26'd3};	// power-up image
		model[1] = {OP_ADDI, 5'd30, 5'd30, 16'h0008};
		model[2] = {OP_SW, 5'd30, 5'd6, 16'hfffb};
		model[3] = {OP_LI, 5'd0, 5'd20, 16'h0009};
		model[4] = {OP_JAL, 26'd6};
		model[5] = {OP_MOV, 5'd1, 5'd11, 16'h0000};
		model[6] = {OP_OUT, 5'd0, 5'd6, 16'h0002};
		model[7] = {OP_HALT, 26'd0};

		add_step(K_RUN, '0, '0, '0, `AXI_RESP_OKAY);	// boot image
		add_step(K_DONE, '0, '0, 32'h2, `AXI_RESP_OKAY);
		add_step(K_RUN, '0, '0, '0, `AXI_RESP_OKAY);	// restart after halt
		add_step(K_DONE, '0, '0, 32'h2, `AXI_RESP_OKAY);
		add_step(K_WR, 32'h000, {OP_LI, 5'd0, 5'd4, 16'h0010}, '0, `AXI_RESP_OKAY);
		add_step(K_WR, 32'h004, {OP_JF, 5'd4, 5'd0, 16'h0003}, '0, `AXI_RESP_OKAY);
		add_step(K_WR, 32'h008, {OP_JAL, 26'd6}, '0, `AXI_RESP_OKAY);
		add_step(K_WR, 32'h018, {OP_ADDI, 5'd4, 5'd4, 16'h0001}, '0, `AXI_RESP_OKAY);
		add_step(K_WR, 32'h01c, {OP_J, 26'd20}, '0, `AXI_RESP_OKAY);
		add_step(K_WR, 32'h0a0, {OP_HALT, 26'd0}, '0, `AXI_RESP_OKAY);
		add_step(K_RD, 32'h004, '0, {OP_JF, 5'd4, 5'd0, 16'h0003}, `AXI_RESP_OKAY);
		add_step(K_RD, 32'h0a0, '0, {OP_HALT, 26'd0}, `AXI_RESP_OKAY);
		add_step(K_WR, 32'h800, 32'hdead_beef, '0, `AXI_RESP_SLVERR);
		add_step(K_RD, 32'h800, '0, '0, `AXI_RESP_SLVERR);
		add_step(K_RD, `CTRL_ADDR, '0, '0, `AXI_RESP_OKAY);
		add_step(K_RUN, '0, '0, '0, `AXI_RESP_OKAY);	// host traffic during fetch
		add_step(K_RD, `STAT_ADDR, '0, 32'h1, `AXI_RESP_OKAY);
		add_step(K_RD, 32'h008, '0, {OP_JAL, 26'd6}, `AXI_RESP_OKAY);
		add_step(K_WR, 32'h190, 32'h1234_5678, '0, `AXI_RESP_OKAY);
		add_step(K_RD, 32'h190, '0, 32'h1234_5678, `AXI_RESP_OKAY);
		add_step(K_DONE, '0, '0, 32'h2, `AXI_RESP_OKAY);
		add_step(K_WR, 32'h01c, {OP_J, 26'd128}, '0, `AXI_RESP_OKAY);	// jump out of memory
		add_step(K_RUN, '0, '0, '0, `AXI_RESP_OKAY);
		add_step(K_DONE, '0, '0, 32'h4, `AXI_RESP_OKAY);
		cycle_limit = 40 * steps.size() + 2000;

		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		foreach (steps[i]) begin
			st = steps[i];
			case (st.kind)
				K_WR: begin
					axil_write(st.addr, st.data, resp);
					check_resp("bresp", resp, st.resp);
					if (st.addr < `IMEM_DEPTH * 4) model[st.addr[`IMEM_AW+1:2]] = st.data;
				end
				K_RD: begin
					axil_read(st.addr, rd, resp);
					check_resp("rresp", resp, st.resp);
					if (st.resp == `AXI_RESP_OKAY) check_word("rdata", rd, st.exp);
				end
				K_RUN: begin
					walk_program();
					axil_write(`CTRL_ADDR, 32'h1, resp);
					check_resp("bresp", resp, `AXI_RESP_OKAY);
				end
				default: begin
					while (exp_q.size() != 0 || !(halted || fault)) @(posedge clk);
					axil_read(`STAT_ADDR, rd, resp);
					check_resp("rresp", resp, `AXI_RESP_OKAY);
					check_word("status", rd, st.exp);
					check_word("status pins", {29'd0, fault, halted, running}, st.exp);
				end
			endcase
		end

		@(negedge clk);
		if (u_imem_subsys_top.u_imem_subsys_chk.n_fail == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			report_fail();
		end
	end

endmodule

/* tb.f */
+incdir+include
hw/isa_pkg.sv
hw/bus_pkg.sv
hw/instr_mem.sv
hw/mem_arbiter.sv
hw/axil_loader.sv
hw/fetch_unit.sv
hw/imem_subsys_top.sv
verification/imem_subsys_chk.sv
verification/imem_subsys_tb.sv

/* Bender.yml */
package:
  name: imem_subsys

export_include_dirs:
  - include

sources:
  - files:
      - hw/isa_pkg.sv
      - hw/bus_pkg.sv
      - hw/instr_mem.sv
      - hw/mem_arbiter.sv
      - hw/axil_loader.sv
      - hw/fetch_unit.sv
      - hw/imem_subsys_top.sv
  - target: simulation
    files:
      - verification/imem_subsys_chk.sv
      - verification/imem_subsys_tb.sv
